// File: testbench/program_stimulus.mem
// program word count, then one instruction word per line loaded from RESET_PC up
// commit record count, then one record per line as pc rd rd_wen data
0000002B
00500093 // 00 addi x1, x0, 5
FFD08113 // 04 addi x2, x1, -3
002081B3 // 08 add x3, x1, x2
40118233 // 0c sub x4, x3, x1
800002B7 // 10 lui x5, 0x80000
4042D313 // 14 srai x6, x5, 4
0042D3B3 // 18 srl x7, x5, x4
00132433 // 1c slt x8, x6, x1
001334B3 // 20 sltu x9, x6, x1
00001517 // 24 auipc x10, 0x1
0FF54593 // 28 xori x11, x10, 0xff
0025E633 // 2c or x12, x11, x2
0F067693 // 30 andi x13, x12, 0xf0
00209733 // 34 sll x14, x1, x2
00708013 // 38 addi x0, x1, 7
001007B3 // 3c add x15, x0, x1
00F08463 // 40 beq x1, x15, +8 taken
00100813 // 44 skipped
00F09463 // 48 bne x1, x15, +8 not taken
00134463 // 4c blt x6, x1, +8 taken
00100813 // 50 skipped
00135463 // 54 bge x6, x1, +8 not taken
00136463 // 58 bltu x6, x1, +8 not taken
00137463 // 5c bgeu x6, x1, +8 taken
00100813 // 60 skipped
0020D463 // 64 bge x1, x2, +8 taken
00100813 // 68 skipped
00208463 // 6c beq x1, x2, +8 not taken
00209463 // 70 bne x1, x2, +8 taken
00100813 // 74 skipped
00116463 // 78 bltu x2, x1, +8 taken
00100813 // 7c skipped
0020C463 // 80 blt x1, x2, +8 not taken
00117463 // 84 bgeu x2, x1, +8 not taken
00C008EF // 88 jal x17, +12
00100813 // 8c skipped
00100813 // 90 skipped
01988913 // 94 addi x18, x17, 0x19
000909E7 // 98 jalr x19, 0(x18)
00100813 // 9c skipped
00100813 // a0 skipped
01198A33 // a4 add x20, x19, x17
0000006F // a8 jal x0, 0
00000021
00000000 00000001 00000001 00000005
00000004 00000002 00000001 00000002
00000008 00000003 00000001 00000007
0000000C 00000004 00000001 00000002
00000010 00000005 00000001 80000000
00000014 00000006 00000001 F8000000
00000018 00000007 00000001 20000000
0000001C 00000008 00000001 00000001
00000020 00000009 00000001 00000000
00000024 0000000A 00000001 00001024
00000028 0000000B 00000001 000010DB
0000002C 0000000C 00000001 000010DB
00000030 0000000D 00000001 000000D0
00000034 0000000E 00000001 00000014
00000038 00000000 00000000 00000000
0000003C 0000000F 00000001 00000005
00000040 00000008 00000000 00000000
00000048 00000008 00000000 00000000
0000004C 00000008 00000000 00000000
00000054 00000008 00000000 00000000
00000058 00000008 00000000 00000000
0000005C 00000008 00000000 00000000
00000064 00000008 00000000 00000000
0000006C 00000008 00000000 00000000
00000070 00000008 00000000 00000000
00000078 00000008 00000000 00000000
00000080 00000008 00000000 00000000
00000084 00000008 00000000 00000000
00000088 00000011 00000001 0000008C
00000094 00000012 00000001 000000A5
00000098 00000013 00000001 0000009C
000000A4 00000014 00000001 00000128
000000A8 00000000 00000000 00000000

// File: src.f
rtl/core_pkg.sv
rtl/regfile.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/execute_unit.sv
rtl/core_top.sv
testbench/core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module core_tb -f src.f
./obj_dir/Vcore_tb

// File: testbench/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	localparam int              CLOCK_PERIOD = 40;
	localparam int              RESET_CYCLES = 3;
	localparam int              MAX_IDLE     = 3;
	localparam int              STIM_WORDS   = 256;
	localparam int              IMEM_WORDS   = 64;
	localparam logic [31:0]     SEED         = 32'h56f7;
	localparam core_pkg::word_t RESET_PC     = 32'h0000_0000;

	logic                 clock = 1'b0;
	logic                 reset;
	core_pkg::fetch_req_t fetch_req;
	core_pkg::fetch_rsp_t fetch_rsp = '0;
	core_pkg::commit_t    commit;

	logic [31:0] stim [STIM_WORDS];
	logic [31:0] imem [IMEM_WORDS];
	int          prog_len;
	int          exp_base;
	int          exp_count;
	int          commit_idx = 0;
	logic        mem_pending;
	int          idle_left;
	logic [31:0] pending_pc;

	core_top #(
		.RESET_PC(RESET_PC)
	) dut (
		.clock_i    (clock),
		.reset_i    (reset),
		.fetch_req_o(fetch_req),
		.fetch_rsp_i(fetch_rsp),
		.commit_o   (commit)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	task automatic stop_with_failure(input string reason);
		$display("Checks failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			stop_with_failure($sformatf("value mismatch in %s", name));
		end
	endtask

	// pc, rd, rd_wen, data as four words of the data file
	function automatic logic [127:0] expected_record(input int idx);
		int base;
		base = exp_base + idx * 4;
		return {stim[base], stim[base + 1], stim[base + 2], stim[base + 3]};
	endfunction

	// instruction memory answering after 0 to MAX_IDLE idle cycles
	always @(negedge clock) begin : mem_model
		int word_offset;
		if (reset) begin
			fetch_rsp   <= '0;
			mem_pending = 1'b0;
			idle_left   = 0;
		end else begin
			// response was taken on the rising edge just passed
			if (fetch_rsp.valid)
				mem_pending = 1'b0;
			fetch_rsp.valid <= 1'b0;
			if (fetch_req.valid) begin
				if (!mem_pending) begin
					mem_pending = 1'b1;
					pending_pc  = fetch_req.pc;
					idle_left   = int'($urandom_range(MAX_IDLE, 0));
				end else if (fetch_req.pc !== pending_pc) begin
					stop_with_failure("fetch request pc changed while waiting for memory");
				end
				word_offset = int'((fetch_req.pc - RESET_PC) >> 2);
				if (fetch_req.pc[1:0] != 2'b00 || word_offset >= prog_len)
					stop_with_failure("fetch request outside the program");
				if (idle_left == 0) begin
					fetch_rsp.valid <= 1'b1;
					fetch_rsp.inst  <= imem[word_offset];
				end else begin
					idle_left = idle_left - 1;
				end
			end
		end
	end

	// commits compared in program order
	always @(negedge clock) begin
		if (!reset && commit.valid && commit_idx < exp_count) begin
			check_value($sformatf("commit %0d", commit_idx), expected_record(commit_idx),
				{commit.pc, 27'd0, commit.rd, 31'd0, commit.rd_wen, commit.data});
			commit_idx = commit_idx + 1;
		end
	end

	initial begin : watchdog
		@(negedge clock);
		repeat (prog_len * 8 + 50) @(posedge clock);
		stop_with_failure("timeout, the core stopped committing before the end of the program");
	end

	initial begin
		reset = 1'b1;
		void'($urandom(SEED));
		$readmemh("testbench/program_stimulus.mem", stim);
		prog_len = int'(stim[0]);
		if (prog_len < 1 || prog_len > IMEM_WORDS)
			stop_with_failure("program size in the stimulus file is out of range");
		exp_count = int'(stim[prog_len + 1]);
		exp_base  = prog_len + 2;
		if (exp_count < 1 || exp_base + exp_count * 4 > STIM_WORDS)
			stop_with_failure("commit record count in the stimulus file is out of range");
		for (int i = 0; i < prog_len; i++)
			imem[i] = stim[i + 1];

		repeat (RESET_CYCLES) begin
			@(negedge clock);
			check_value("reset request", 128'd0, {127'd0, fetch_req.valid});
			check_value("reset commit", 128'd0, {127'd0, commit.valid});
		end
		reset = 1'b0;

		// first request one cycle after reset
		@(negedge clock);
		check_value("first request valid", 128'd1, {127'd0, fetch_req.valid});
		check_value("first request pc", {96'd0, RESET_PC}, {96'd0, fetch_req.pc});

		while (commit_idx < exp_count)
			@(negedge clock);

		$display("All checks passed");
		$finish;
	end

endmodule

// File: rtl/core_top.sv
`timescale 1ns/1ps

module core_top #(
	parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic                 clock_i,
	input  logic                 reset_i,
	output core_pkg::fetch_req_t fetch_req_o,
	input  core_pkg::fetch_rsp_t fetch_rsp_i,
	output core_pkg::commit_t    commit_o
);

	logic                if_valid;
	core_pkg::word_t     if_pc;
	core_pkg::word_t     if_inst;

	logic                id_valid_q;
	core_pkg::word_t     id_pc_q;
	core_pkg::word_t     id_inst_q;

	core_pkg::reg_addr_t rs1_addr;
	core_pkg::reg_addr_t rs2_addr;
	core_pkg::word_t     rs1_data;
	core_pkg::word_t     rs2_data;
	core_pkg::decoded_t  decoded;

	core_pkg::decoded_t  ex_q;
	core_pkg::exec_t     exec_res;
	core_pkg::redirect_t redirect;

	core_pkg::exec_t     wb_q;
	logic                wb_wen;
	core_pkg::commit_t   commit_q;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clock_i    (clock_i),
		.reset_i    (reset_i),
		.fetch_req_o(fetch_req_o),
		.fetch_rsp_i(fetch_rsp_i),
		.redirect_i (redirect),
		.if_valid_o (if_valid),
		.if_pc_o    (if_pc),
		.if_inst_o  (if_inst)
	);

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			id_valid_q <= 1'b0;
		end else begin
			id_valid_q <= if_valid;
			id_pc_q    <= if_pc;
			id_inst_q  <= if_inst;
		end
	end

	decode_stage u_decode (
		.id_valid_i(id_valid_q),
		.id_pc_i   (id_pc_q),
		.id_inst_i (id_inst_q),
		.rs1_addr_o(rs1_addr),
		.rs2_addr_o(rs2_addr),
		.rs1_data_i(rs1_data),
		.rs2_data_i(rs2_data),
		.ex_fwd_i  (exec_res),
		.wb_fwd_i  (wb_q),
		.decoded_o (decoded)
	);

	regfile u_regfile (
		.clock_i   (clock_i),
		.reset_i   (reset_i),
		.rs1_addr_i(rs1_addr),
		.rs2_addr_i(rs2_addr),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data),
		.wr_en_i   (wb_wen),
		.wr_addr_i (wb_q.rd),
		.wr_data_i (wb_q.result)
	);

	always_ff @(posedge clock_i) begin
		if (reset_i)
			ex_q.valid <= 1'b0;
		else
			ex_q <= decoded;
	end

	execute_unit u_execute (
		.ex_i      (ex_q),
		.exec_o    (exec_res),
		.redirect_o(redirect)
	);

	always_ff @(posedge clock_i) begin
		if (reset_i)
			wb_q.valid <= 1'b0;
		else
			wb_q <= exec_res;
	end

	// x0 destinations retire without a write
	assign wb_wen = wb_q.valid & wb_q.rd_wen & (wb_q.rd != 5'd0);

	// commit reported on the same edge the regfile takes the write
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			commit_q.valid <= 1'b0;
		end else begin
			commit_q.valid  <= wb_q.valid;
			commit_q.pc     <= wb_q.pc;
			commit_q.rd     <= wb_q.rd;
			commit_q.rd_wen <= wb_wen;
			commit_q.data   <= wb_wen ? wb_q.result : '0;
		end
	end

	assign commit_o = commit_q;

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  core_pkg::decoded_t  ex_i,
	output core_pkg::exec_t     exec_o,
	output core_pkg::redirect_t redirect_o
);

	core_pkg::word_t op_a;
	core_pkg::word_t op_b;
	core_pkg::word_t alu_res;
	core_pkg::word_t link;
	core_pkg::word_t jump_target;
	logic [4:0]      shamt;
	logic            taken;
	logic            is_jump;

	assign op_a  = ex_i.use_pc ? ex_i.pc : ex_i.src1;
	assign op_b  = ex_i.use_imm ? ex_i.imm : ex_i.src2;
	assign shamt = op_b[4:0];

	always_comb begin
		case (ex_i.alu_op)
			core_pkg::ALU_ADD:    alu_res = op_a + op_b;
			core_pkg::ALU_SUB:    alu_res = op_a - op_b;
			core_pkg::ALU_SLL:    alu_res = op_a << shamt;
			core_pkg::ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
			core_pkg::ALU_SLTU:   alu_res = {31'd0, op_a < op_b};
			core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
			core_pkg::ALU_SRL:    alu_res = op_a >> shamt;
			core_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
			core_pkg::ALU_OR:     alu_res = op_a | op_b;
			core_pkg::ALU_AND:    alu_res = op_a & op_b;
			core_pkg::ALU_PASS_B: alu_res = op_b;
			default:              alu_res = '0;
		endcase
	end

	// branch operands come straight from the sources, not the alu inputs
	always_comb begin
		case (ex_i.funct3)
			3'b000:  taken = ex_i.src1 == ex_i.src2;
			3'b001:  taken = ex_i.src1 != ex_i.src2;
			3'b100:  taken = $signed(ex_i.src1) < $signed(ex_i.src2);
			3'b101:  taken = $signed(ex_i.src1) >= $signed(ex_i.src2);
			3'b110:  taken = ex_i.src1 < ex_i.src2;
			3'b111:  taken = ex_i.src1 >= ex_i.src2;
			default: taken = 1'b0;
		endcase
	end

	assign is_jump = ex_i.is_jal | ex_i.is_jalr;
	assign link    = ex_i.pc + 32'd4;

	// alu already holds pc+imm or rs1+imm here
	assign jump_target = {alu_res[core_pkg::XLEN-1:1], 1'b0};

	assign exec_o.valid  = ex_i.valid;
	assign exec_o.pc     = ex_i.pc;
	assign exec_o.rd     = ex_i.rd;
	assign exec_o.rd_wen = ex_i.rd_wen;
	assign exec_o.result = is_jump ? link : alu_res;

	assign redirect_o.valid  = ex_i.valid & (ex_i.is_branch | is_jump);
	assign redirect_o.target = (is_jump | (ex_i.is_branch & taken)) ? jump_target : link;

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                 id_valid_i,
	input  core_pkg::word_t      id_pc_i,
	input  core_pkg::inst_u      id_inst_i,
	output core_pkg::reg_addr_t  rs1_addr_o,
	output core_pkg::reg_addr_t  rs2_addr_o,
	input  core_pkg::word_t      rs1_data_i,
	input  core_pkg::word_t      rs2_data_i,
	input  core_pkg::exec_t      ex_fwd_i,
	input  core_pkg::exec_t      wb_fwd_i,
	output core_pkg::decoded_t   decoded_o
);

	core_pkg::word_t imm_i;
	core_pkg::word_t imm_b;
	core_pkg::word_t imm_u;
	core_pkg::word_t imm_j;
	logic            shift_alt;

	// execute result wins over writeback, then the regfile
	function automatic core_pkg::word_t pick_src(input core_pkg::reg_addr_t addr,
			input core_pkg::word_t rf_data, input core_pkg::exec_t ex,
			input core_pkg::exec_t wb);
		core_pkg::word_t value;
		if (addr == 5'd0)
			value = '0;
		else if (ex.valid && ex.rd_wen && ex.rd == addr)
			value = ex.result;
		else if (wb.valid && wb.rd_wen && wb.rd == addr)
			value = wb.result;
		else
			value = rf_data;
		return value;
	endfunction

	function automatic core_pkg::alu_op_e alu_from_funct(input logic [2:0] funct3,
			input logic alt);
		core_pkg::alu_op_e op;
		case (funct3)
			3'b000: op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			3'b001: op = core_pkg::ALU_SLL;
			3'b010: op = core_pkg::ALU_SLT;
			3'b011: op = core_pkg::ALU_SLTU;
			3'b100: op = core_pkg::ALU_XOR;
			3'b101: op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			3'b110: op = core_pkg::ALU_OR;
			default: op = core_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	assign rs1_addr_o = id_inst_i.r_fmt.rs1;
	assign rs2_addr_o = id_inst_i.r_fmt.rs2;

	assign imm_i = {{20{id_inst_i.i_fmt.imm[11]}}, id_inst_i.i_fmt.imm};
	assign imm_b = {{19{id_inst_i.b_fmt.imm12}}, id_inst_i.b_fmt.imm12, id_inst_i.b_fmt.imm11,
		id_inst_i.b_fmt.imm10_5, id_inst_i.b_fmt.imm4_1, 1'b0};
	assign imm_u = {id_inst_i.u_fmt.imm, 12'b0};
	assign imm_j = {{11{id_inst_i.j_fmt.imm20}}, id_inst_i.j_fmt.imm20,
		id_inst_i.j_fmt.imm19_12, id_inst_i.j_fmt.imm11, id_inst_i.j_fmt.imm10_1, 1'b0};

	// only srai uses imm bit 10 as the arithmetic select
	assign shift_alt = (id_inst_i.i_fmt.funct3 == 3'b101) & id_inst_i.i_fmt.imm[10];

	always_comb begin
		decoded_o        = '0;
		decoded_o.valid  = id_valid_i;
		decoded_o.pc     = id_pc_i;
		decoded_o.src1   = pick_src(rs1_addr_o, rs1_data_i, ex_fwd_i, wb_fwd_i);
		decoded_o.src2   = pick_src(rs2_addr_o, rs2_data_i, ex_fwd_i, wb_fwd_i);
		decoded_o.funct3 = id_inst_i.r_fmt.funct3;
		decoded_o.rd     = id_inst_i.r_fmt.rd;
		decoded_o.alu_op = core_pkg::ALU_ADD;
		case (id_inst_i.r_fmt.opcode)
			core_pkg::OPC_OP: begin
				decoded_o.alu_op = alu_from_funct(id_inst_i.r_fmt.funct3,
					id_inst_i.r_fmt.funct7[5]);
				decoded_o.rd_wen = 1'b1;
			end
			core_pkg::OPC_OP_IMM: begin
				decoded_o.alu_op  = alu_from_funct(id_inst_i.i_fmt.funct3, shift_alt);
				decoded_o.imm     = imm_i;
				decoded_o.use_imm = 1'b1;
				decoded_o.rd_wen  = 1'b1;
			end
			core_pkg::OPC_LUI: begin
				decoded_o.alu_op  = core_pkg::ALU_PASS_B;
				decoded_o.imm     = imm_u;
				decoded_o.use_imm = 1'b1;
				decoded_o.rd_wen  = 1'b1;
			end
			core_pkg::OPC_AUIPC: begin
				decoded_o.imm     = imm_u;
				decoded_o.use_imm = 1'b1;
				decoded_o.use_pc  = 1'b1;
				decoded_o.rd_wen  = 1'b1;
			end
			core_pkg::OPC_BRANCH: begin
				decoded_o.imm       = imm_b;
				decoded_o.use_imm   = 1'b1;
				decoded_o.use_pc    = 1'b1;
				decoded_o.is_branch = 1'b1;
			end
			core_pkg::OPC_JAL: begin
				decoded_o.imm     = imm_j;
				decoded_o.use_imm = 1'b1;
				decoded_o.use_pc  = 1'b1;
				decoded_o.is_jal  = 1'b1;
				decoded_o.rd_wen  = 1'b1;
			end
			core_pkg::OPC_JALR: begin
				decoded_o.imm     = imm_i;
				decoded_o.use_imm = 1'b1;
				decoded_o.is_jalr = 1'b1;
				decoded_o.rd_wen  = 1'b1;
			end
			default: begin
				// unknown opcode retires as a nop
				decoded_o.rd_wen = 1'b0;
			end
		endcase
	end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic                 clock_i,
	input  logic                 reset_i,
	output core_pkg::fetch_req_t fetch_req_o,
	input  core_pkg::fetch_rsp_t fetch_rsp_i,
	input  core_pkg::redirect_t  redirect_i,
	output logic                 if_valid_o,
	output core_pkg::word_t      if_pc_o,
	output core_pkg::word_t      if_inst_o
);

	core_pkg::word_t pc_q;
	logic            req_q;
	logic            wait_q;
	core_pkg::inst_u rsp_inst;
	logic            rsp_fire;
	logic            is_ctrl;

	assign rsp_inst = fetch_rsp_i.inst;
	assign rsp_fire = req_q & fetch_rsp_i.valid;

	// control transfers stall fetch until execute resolves them
	assign is_ctrl = (rsp_inst.r_fmt.opcode == core_pkg::OPC_BRANCH) |
		(rsp_inst.r_fmt.opcode == core_pkg::OPC_JAL) |
		(rsp_inst.r_fmt.opcode == core_pkg::OPC_JALR);

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			pc_q   <= RESET_PC;
			req_q  <= 1'b0;
			wait_q <= 1'b0;
		end else if (redirect_i.valid) begin
			pc_q   <= redirect_i.target;
			req_q  <= 1'b1;
			wait_q <= 1'b0;
		end else if (rsp_fire) begin
			if (is_ctrl) begin
				req_q  <= 1'b0;
				wait_q <= 1'b1;
			end else begin
				pc_q  <= pc_q + 32'd4;
				req_q <= 1'b1;
			end
		end else if (!wait_q) begin
			req_q <= 1'b1;
		end
	end

	assign fetch_req_o.valid = req_q;
	assign fetch_req_o.pc    = pc_q;

	assign if_valid_o = rsp_fire;
	assign if_pc_o    = pc_q;
	assign if_inst_o  = fetch_rsp_i.inst;

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic                clock_i,
	input  logic                reset_i,
	input  core_pkg::reg_addr_t rs1_addr_i,
	input  core_pkg::reg_addr_t rs2_addr_i,
	output core_pkg::word_t     rs1_data_o,
	output core_pkg::word_t     rs2_data_o,
	input  logic                wr_en_i,
	input  core_pkg::reg_addr_t wr_addr_i,
	input  core_pkg::word_t     wr_data_i
);

	core_pkg::word_t regs [32];

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en_i && wr_addr_i != 5'd0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// x0 reads as zero
	assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_e;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		reg_addr_t   rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		reg_addr_t  rd;
		opcode_e    opcode;
	} j_fmt_t;

	// one instruction word seen through each encoding format
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	typedef struct packed {
		logic  valid;
		word_t pc;
	} fetch_req_t;

	typedef struct packed {
		logic  valid;
		word_t inst;
	} fetch_rsp_t;

	typedef struct packed {
		logic       valid;
		word_t      pc;
		word_t      src1;
		word_t      src2;
		word_t      imm;
		alu_op_e    alu_op;
		logic       use_imm;
		logic       use_pc;
		logic       is_branch;
		logic       is_jal;
		logic       is_jalr;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic       rd_wen;
	} decoded_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t rd;
		logic      rd_wen;
		word_t     result;
	} exec_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t rd;
		logic      rd_wen;
		word_t     data;
	} commit_t;

	typedef struct packed {
		logic  valid;
		word_t target;
	} redirect_t;

endpackage
